// File: all.f
common/csr_pkg.sv
common/bfs_pkg.sv
csr/csr_counters.sv
bfs/bfs_regs.sv
csr/csr_unit.sv
verilog/csr_subsys_top.sv
verification/csr_sva.sv
verification/csr_tb.sv

// File: verification/csr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_tb;

  localparam int qbase_w = 24;
  localparam int n_ops   = 400;
  localparam logic [31:0] qbase_mask = 32'((64'd1 << qbase_w) - 64'd1);

  logic                clk = 1'b0;
  logic                arst_n;
  logic                issue_valid;
  csr_pkg::csr_issue_t issue;
  logic                stall;
  logic                wb_valid;
  csr_pkg::csr_wb_t    wb;
  logic                ret_valid;
  logic                l2_req;
  logic                uart_tx_valid;
  logic [7:0]          uart_tx_data;

  // reference model state
  logic [63:0] m_cycle;
  logic [63:0] m_instret;
  logic [7:0]  m_uart;
  logic [31:0] m_root;
  logic [31:0] m_targ;
  logic [31:0] m_qbase;
  logic [31:0] m_qsize;
  logic        cnt_wr_pend;
  logic [1:0]  cnt_wr_sel;
  logic [31:0] cnt_wr_data;
  logic        instret_hold;
  int          l2_left;

  csr_subsys_top #(
    .qbase_w (qbase_w)
  ) u_dut (
    .clk           (clk),
    .arst_n        (arst_n),
    .issue_valid   (issue_valid),
    .issue         (issue),
    .stall         (stall),
    .wb_valid      (wb_valid),
    .wb            (wb),
    .ret_valid     (ret_valid),
    .l2_req        (l2_req),
    .uart_tx_valid (uart_tx_valid),
    .uart_tx_data  (uart_tx_data)
  );

  bind csr_unit csr_sva u_sva (
    .clk           (clk),
    .arst_n        (arst_n),
    .wb_valid      (wb_valid),
    .bfs_req_valid (bfs_req_valid),
    .bfs_rsp_valid (bfs_rsp_valid)
  );

  always #4 clk = ~clk;

  // counter model followed by random retire and l2 traffic
  always @(posedge clk) begin
    if (!arst_n) begin
      m_cycle   = 64'd0;
      m_instret = 64'd0;
    end else begin
      m_cycle   = m_cycle + 64'd1;
      m_instret = m_instret + ((ret_valid && !instret_hold) ? 64'd1 : 64'd0);
      if (cnt_wr_pend) begin
        case (cnt_wr_sel)
          2'd0: m_cycle[31:0] = cnt_wr_data;
          2'd1: m_cycle[63:32] = cnt_wr_data;
          2'd2: m_instret[31:0] = cnt_wr_data;
          default: m_instret[63:32] = cnt_wr_data;
        endcase
      end
    end
    cnt_wr_pend  = 1'b0;
    instret_hold = 1'b0;
    ret_valid <= ($urandom_range(2, 0) == 0);
    if (l2_left > 0) begin
      l2_left = l2_left - 1;
      l2_req <= 1'b1;
    end else if ($urandom_range(15, 0) == 0) begin
      l2_left = $urandom_range(5, 2);
      l2_req <= 1'b1;
    end else begin
      l2_req <= 1'b0;
    end
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    stop_with_error($sformatf("[ERROR] %s expected 0x%08h got 0x%08h", name, exp, got));
  endtask

  task automatic check_wb(input csr_pkg::csr_wb_t exp, input csr_pkg::csr_wb_t got,
                          input logic chk_result);
    if (got.error !== exp.error) report_mismatch("wb.error", 32'(exp.error), 32'(got.error));
    if (got.robid !== exp.robid) report_mismatch("wb.robid", 32'(exp.robid), 32'(got.robid));
    if (got.rd !== exp.rd) report_mismatch("wb.rd", 32'(exp.rd), 32'(got.rd));
    if (chk_result && got.result !== exp.result)
      report_mismatch("wb.result", exp.result, got.result);
  endtask

  task automatic check_uart(input logic exp_valid, input logic [7:0] exp_data);
    if (uart_tx_valid !== exp_valid)
      report_mismatch("uart_tx_valid", 32'(exp_valid), 32'(uart_tx_valid));
    if (exp_valid && uart_tx_data !== exp_data)
      report_mismatch("uart_tx_data", 32'(exp_data), 32'(uart_tx_data));
  endtask

  task automatic check_stall(input logic exp);
    if (stall !== exp) report_mismatch("stall", 32'(exp), 32'(stall));
  endtask

  function automatic csr_pkg::csr_addr_t csr_addr_at(input int n);
    case (n)
      0: return csr_pkg::addr_mcycle;
      1: return csr_pkg::addr_mcycleh;
      2: return csr_pkg::addr_minstret;
      3: return csr_pkg::addr_minstreth;
      4: return csr_pkg::addr_muartstat;
      5: return csr_pkg::addr_muarttx;
      default: return csr_pkg::addr_ml2stat;
    endcase
  endfunction

  task automatic run_access(input csr_pkg::csr_issue_t req);
    csr_pkg::csr_wb_t exp;
    logic [31:0]      cur;
    logic [31:0]      nv;
    logic             mapped;
    logic [3:0]       idx;
    logic             wr;
    logic             is_bfs;
    logic             rmw;
    logic             l2_wr;
    int               lat;
    wr     = (req.op != csr_pkg::op_read);
    idx    = req.addr[3:0];
    is_bfs = (req.addr[11:4] == csr_pkg::addr_bfs_page);
    rmw    = is_bfs && (req.op == csr_pkg::op_set || req.op == csr_pkg::op_clear);
    l2_wr  = wr && (req.addr == csr_pkg::addr_ml2stat);
    // idle cycle between accesses
    @(negedge clk);
    check_stall(1'b0);
    if (wb_valid !== 1'b0) report_mismatch("wb_valid", 32'd0, 32'(wb_valid));
    @(posedge clk);
    issue_valid <= 1'b1;
    issue       <= req;
    @(posedge clk);
    issue_valid <= 1'b0;
    for (lat = 1; lat <= 50; lat++) begin
      @(negedge clk);
      if (wb_valid) break;
      check_stall(1'b1);
      if (uart_tx_valid) stop_with_error("uart_tx_valid pulsed outside a writeback cycle");
      if (l2_wr && !l2_req) stop_with_error("ml2stat write still stalled after l2_req fell");
    end
    if (!wb_valid) stop_with_error("timed out after 50 cycles waiting for wb_valid");
    if (!l2_wr && lat != ((is_bfs && !rmw) ? 2 : 1))
      stop_with_error($sformatf("writeback came %0d cycles after acceptance", lat));
    if (l2_wr && l2_req)
      stop_with_error("ml2stat write completed while l2_req was still high");
    mapped = 1'b1;
    case (req.addr)
      csr_pkg::addr_mcycle:    cur = m_cycle[31:0];
      csr_pkg::addr_mcycleh:   cur = m_cycle[63:32];
      csr_pkg::addr_minstret:  cur = m_instret[31:0];
      csr_pkg::addr_minstreth: cur = m_instret[63:32];
      csr_pkg::addr_muartstat: cur = 32'h5;
      csr_pkg::addr_muarttx:   cur = {24'd0, m_uart};
      csr_pkg::addr_ml2stat:   cur = {31'd0, l2_req};
      default: begin
        cur    = 32'd0;
        mapped = is_bfs;
      end
    endcase
    if (is_bfs) begin
      case (idx)
        bfs_pkg::idx_stat:  cur = {31'd0, m_qsize != 32'd0};
        bfs_pkg::idx_root:  cur = m_root;
        bfs_pkg::idx_targ:  cur = m_targ;
        bfs_pkg::idx_qbase: cur = m_qbase;
        bfs_pkg::idx_qsize: cur = m_qsize;
        default:            mapped = 1'b0;
      endcase
    end
    case (req.op)
      csr_pkg::op_write: nv = req.operand;
      csr_pkg::op_set:   nv = cur | req.operand;
      csr_pkg::op_clear: nv = cur & ~req.operand;
      default:           nv = cur;
    endcase
    exp.error  = !mapped || (wr && req.addr[11:10] == 2'b11) || rmw ||
                 (is_bfs && wr && idx == bfs_pkg::idx_stat);
    exp.robid  = req.robid;
    exp.rd     = req.rd;
    exp.result = cur;
    // the bfs window never sees an rmw so its result is undefined
    check_wb(exp, wb, !rmw);
    check_uart(wr && !exp.error && req.addr == csr_pkg::addr_muarttx, nv[7:0]);
    if (wr && !exp.error) begin
      cnt_wr_data = nv;
      case (req.addr)
        csr_pkg::addr_mcycle:    {cnt_wr_pend, cnt_wr_sel} = 3'b100;
        csr_pkg::addr_mcycleh:   {cnt_wr_pend, cnt_wr_sel} = 3'b101;
        csr_pkg::addr_minstret:  {cnt_wr_pend, cnt_wr_sel} = 3'b110;
        csr_pkg::addr_minstreth: {cnt_wr_pend, cnt_wr_sel} = 3'b111;
        csr_pkg::addr_muarttx:   m_uart = nv[7:0];
        default: ;
      endcase
      if (is_bfs) begin
        case (idx)
          bfs_pkg::idx_root:  m_root = nv;
          bfs_pkg::idx_targ:  m_targ = nv;
          bfs_pkg::idx_qbase: m_qbase = nv & qbase_mask;
          default:            m_qsize = nv;
        endcase
      end
    end
    if (wr && req.addr == csr_pkg::addr_minstret) instret_hold = 1'b1;
  endtask

  initial begin
    csr_pkg::csr_issue_t req;
    int                  kind;
    void'($urandom(32'hd7f3a320));
    arst_n       = 1'b0;
    issue_valid  = 1'b0;
    issue        = '0;
    ret_valid    = 1'b0;
    l2_req       = 1'b0;
    cnt_wr_pend  = 1'b0;
    cnt_wr_sel   = 2'd0;
    cnt_wr_data  = 32'd0;
    instret_hold = 1'b0;
    l2_left      = 0;
    m_uart       = 8'd0;
    m_root       = 32'd0;
    m_targ       = 32'd0;
    m_qbase      = 32'd0;
    m_qsize      = 32'd0;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    for (int i = 0; i < n_ops; i++) begin
      req.op      = csr_pkg::csr_op_t'($urandom_range(3, 0));
      req.robid   = 7'($urandom);
      req.rd      = 6'($urandom);
      req.operand = $urandom;
      kind        = $urandom_range(9, 0);
      if (kind < 5) begin
        req.addr = csr_addr_at($urandom_range(6, 0));
      end else if (kind < 8) begin
        req.addr = {csr_pkg::addr_bfs_page, 4'($urandom_range(7, 0))};
      end else begin
        req.addr = 12'($urandom);
      end
      run_access(req);
    end
    repeat (2) @(posedge clk);
    if (u_dut.u_csr_unit.u_sva.fail_count == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      stop_with_error("the bound assertion checker reported failures");
    end
  end

endmodule

`default_nettype wire

// File: verification/csr_sva.sv
`timescale 1ns/1ps
`default_nettype none

module csr_sva (
  input logic clk,
  input logic arst_n,
  input logic wb_valid,
  input logic bfs_req_valid,
  input logic bfs_rsp_valid
);

  int unsigned fail_count = 0;

  // the response cycle is the writeback cycle
  a_wb_with_rsp: assert property (
    @(posedge clk) disable iff (!arst_n) bfs_rsp_valid |-> wb_valid
  ) else begin
    fail_count++;
    $error("bfs response arrived without wb_valid");
  end

  a_rsp_after_req: assert property (
    @(posedge clk) disable iff (!arst_n) bfs_req_valid |=> bfs_rsp_valid
  ) else begin
    fail_count++;
    $error("bfs response missing one cycle after the request");
  end

  // one request per access
  a_single_req: assert property (
    @(posedge clk) disable iff (!arst_n) bfs_req_valid |=> !bfs_req_valid
  ) else begin
    fail_count++;
    $error("bfs_req_valid high for two cycles in a row");
  end

endmodule

`default_nettype wire

// File: verilog/csr_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module csr_subsys_top #(
  parameter int qbase_w = 24
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                issue_valid,
  input  csr_pkg::csr_issue_t issue,
  output logic                stall,
  output logic                wb_valid,
  output csr_pkg::csr_wb_t    wb,
  input  logic                ret_valid,
  input  logic                l2_req,
  output logic                uart_tx_valid,
  output logic [7:0]          uart_tx_data
);

  logic              bfs_req_valid;
  bfs_pkg::bfs_req_t bfs_req;
  logic              bfs_rsp_valid;
  bfs_pkg::bfs_rsp_t bfs_rsp;

  csr_unit u_csr_unit (
    .clk           (clk),
    .arst_n        (arst_n),
    .issue_valid   (issue_valid),
    .issue         (issue),
    .stall         (stall),
    .wb_valid      (wb_valid),
    .wb            (wb),
    .ret_valid     (ret_valid),
    .l2_req        (l2_req),
    .uart_tx_valid (uart_tx_valid),
    .uart_tx_data  (uart_tx_data),
    .bfs_req_valid (bfs_req_valid),
    .bfs_req       (bfs_req),
    .bfs_rsp_valid (bfs_rsp_valid),
    .bfs_rsp       (bfs_rsp)
  );

  // accelerator config and status registers
  bfs_regs #(
    .qbase_w (qbase_w)
  ) u_bfs_regs (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (bfs_req_valid),
    .req       (bfs_req),
    .rsp_valid (bfs_rsp_valid),
    .rsp       (bfs_rsp)
  );

endmodule

`default_nettype wire

// File: csr/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                issue_valid,
  input  csr_pkg::csr_issue_t issue,
  output logic                stall,
  output logic                wb_valid,
  output csr_pkg::csr_wb_t    wb,
  input  logic                ret_valid,
  input  logic                l2_req,
  output logic                uart_tx_valid,
  output logic [7:0]          uart_tx_data,
  output logic                bfs_req_valid,
  output bfs_pkg::bfs_req_t   bfs_req,
  input  logic                bfs_rsp_valid,
  input  bfs_pkg::bfs_rsp_t   bfs_rsp
);

  logic                valid;
  csr_pkg::csr_issue_t stage;
  logic                bfs_pending;
  logic [7:0]          muarttx;
  logic [63:0]         mcycle64;
  logic [63:0]         minstret64;

  logic        sel_mcycle;
  logic        sel_mcycleh;
  logic        sel_minstret;
  logic        sel_minstreth;
  logic        sel_muartstat;
  logic        sel_muarttx;
  logic        sel_bfs;
  logic        sel_ml2stat;
  logic        sel_cnt;
  logic        sel_none;

  logic        is_write;
  logic        read_only;
  logic        bfs_rmw;
  logic        l2_stall;
  logic        err;
  logic        commit;
  logic [31:0] rdata;
  logic [31:0] wdata;
  logic        cnt_wen;
  logic [1:0]  cnt_sel;
  logic        inc_instret;

  // issue latch holds while stalled
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid <= 1'b0;
    end else if (!stall) begin
      valid <= issue_valid;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stage <= '0;
    end else if (!stall && issue_valid) begin
      stage <= issue;
    end
  end

  // address decode
  assign sel_mcycle    = (stage.addr == csr_pkg::addr_mcycle);
  assign sel_mcycleh   = (stage.addr == csr_pkg::addr_mcycleh);
  assign sel_minstret  = (stage.addr == csr_pkg::addr_minstret);
  assign sel_minstreth = (stage.addr == csr_pkg::addr_minstreth);
  assign sel_muartstat = (stage.addr == csr_pkg::addr_muartstat);
  assign sel_muarttx   = (stage.addr == csr_pkg::addr_muarttx);
  assign sel_ml2stat   = (stage.addr == csr_pkg::addr_ml2stat);
  assign sel_bfs       = (stage.addr[11:4] == csr_pkg::addr_bfs_page);

  assign sel_cnt  = sel_mcycle | sel_mcycleh | sel_minstret | sel_minstreth;
  assign sel_none = ~(sel_cnt | sel_muartstat | sel_muarttx | sel_bfs | sel_ml2stat);

  assign is_write  = (stage.op != csr_pkg::op_read);
  assign read_only = &stage.addr[11:10];
  // only plain read and write reach the bfs block
  assign bfs_rmw   = sel_bfs & ((stage.op == csr_pkg::op_set) |
                                (stage.op == csr_pkg::op_clear));

  // read mux
  always_comb begin
    case (1'b1)
      sel_mcycle:    rdata = mcycle64[31:0];
      sel_mcycleh:   rdata = mcycle64[63:32];
      sel_minstret:  rdata = minstret64[31:0];
      sel_minstreth: rdata = minstret64[63:32];
      sel_muartstat: rdata = csr_pkg::uart_stat_value;
      sel_muarttx:   rdata = {24'd0, muarttx};
      sel_bfs:       rdata = bfs_rsp.rdata;
      sel_ml2stat:   rdata = {31'd0, l2_req};
      default:       rdata = 32'd0;
    endcase
  end

  // new value for write, set and clear
  always_comb begin
    case (stage.op)
      csr_pkg::op_write: wdata = stage.operand;
      csr_pkg::op_set:   wdata = rdata | stage.operand;
      csr_pkg::op_clear: wdata = rdata & ~stage.operand;
      default:           wdata = rdata;
    endcase
  end

  // single bfs request with the answer one cycle later
  assign bfs_req_valid = valid & sel_bfs & ~bfs_rmw & ~bfs_pending;
  assign bfs_req.idx   = stage.addr[3:0];
  assign bfs_req.wen   = (stage.op == csr_pkg::op_write);
  assign bfs_req.wdata = stage.operand;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bfs_pending <= 1'b0;
    end else begin
      bfs_pending <= bfs_req_valid;
    end
  end

  // l2 status write waits for the l2 request to drop
  assign l2_stall = valid & is_write & sel_ml2stat & l2_req;

  assign stall    = bfs_req_valid | l2_stall;
  assign wb_valid = valid & ~stall;

  assign err = sel_none | (is_write & read_only) | bfs_rmw |
               (bfs_pending & (~bfs_rsp_valid | bfs_rsp.error));

  assign wb.error  = err;
  assign wb.robid  = stage.robid;
  assign wb.rd     = stage.rd;
  assign wb.result = rdata;

  // writes land in the writeback cycle
  assign commit = wb_valid & is_write & ~err;

  // address bits 1 and 7 give counter and half
  assign cnt_wen     = commit & sel_cnt;
  assign cnt_sel     = {stage.addr[1], stage.addr[7]};
  assign inc_instret = ret_valid & ~(valid & is_write & sel_minstret);

  csr_counters u_counters (
    .clk         (clk),
    .arst_n      (arst_n),
    .cnt_wen     (cnt_wen),
    .cnt_sel     (cnt_sel),
    .cnt_wdata   (wdata),
    .inc_instret (inc_instret),
    .mcycle64    (mcycle64),
    .minstret64  (minstret64)
  );

  // uart transmit
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      muarttx <= 8'd0;
    end else if (commit && sel_muarttx) begin
      muarttx <= wdata[7:0];
    end
  end

  assign uart_tx_valid = commit & sel_muarttx;
  assign uart_tx_data  = wdata[7:0];

endmodule

`default_nettype wire

// File: bfs/bfs_regs.sv
`timescale 1ns/1ps
`default_nettype none

module bfs_regs #(
  parameter int qbase_w = 24
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              req_valid,
  input  bfs_pkg::bfs_req_t req,
  output logic              rsp_valid,
  output bfs_pkg::bfs_rsp_t rsp
);

  logic [31:0]        root;
  logic [31:0]        targ;
  logic [qbase_w-1:0] qbase;
  logic [31:0]        qsize;
  logic [31:0]        rdata;
  logic               mapped;
  logic               bad;
  logic               do_write;

  // read decode, stat bit 0 means configured
  always_comb begin
    mapped = 1'b1;
    case (req.idx)
      bfs_pkg::idx_stat: begin
        rdata = {31'd0, |qsize};
      end
      bfs_pkg::idx_root: begin
        rdata = root;
      end
      bfs_pkg::idx_targ: begin
        rdata = targ;
      end
      bfs_pkg::idx_qbase: begin
        rdata = 32'(qbase);
      end
      bfs_pkg::idx_qsize: begin
        rdata = qsize;
      end
      default: begin
        rdata  = 32'd0;
        mapped = 1'b0;
      end
    endcase
  end

  // stat is read only
  assign bad      = ~mapped | (req.wen & (req.idx == bfs_pkg::idx_stat));
  assign do_write = req_valid & req.wen & ~bad;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      root  <= 32'd0;
      targ  <= 32'd0;
      qbase <= '0;
      qsize <= 32'd0;
    end else if (do_write) begin
      case (req.idx)
        bfs_pkg::idx_root:  root  <= req.wdata;
        bfs_pkg::idx_targ:  targ  <= req.wdata;
        bfs_pkg::idx_qbase: qbase <= req.wdata[qbase_w-1:0];
        default:            qsize <= req.wdata;
      endcase
    end
  end

  // response carries the value before the write
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_valid <= 1'b0;
      rsp       <= '0;
    end else begin
      rsp_valid <= req_valid;
      if (req_valid) begin
        rsp.error <= bad;
        rsp.rdata <= rdata;
      end
    end
  end

endmodule

`default_nettype wire

// File: csr/csr_counters.sv
`timescale 1ns/1ps
`default_nettype none

module csr_counters (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        cnt_wen,
  input  logic [1:0]  cnt_sel,
  input  logic [31:0] cnt_wdata,
  input  logic        inc_instret,
  output logic [63:0] mcycle64,
  output logic [63:0] minstret64
);

  logic [63:0] mcycle_inc;
  logic [63:0] minstret_inc;
  logic [63:0] mcycle_next;
  logic [63:0] minstret_next;

  // free running increments, carry across both halves
  assign mcycle_inc   = mcycle64 + 64'd1;
  assign minstret_inc = minstret64 + {63'd0, inc_instret};

  // cnt_sel[1] picks the counter, cnt_sel[0] the upper half
  always_comb begin
    mcycle_next   = mcycle_inc;
    minstret_next = minstret_inc;
    if (cnt_wen) begin
      case (cnt_sel)
        2'd0: begin
          mcycle_next[31:0] = cnt_wdata;
        end
        2'd1: begin
          mcycle_next[63:32] = cnt_wdata;
        end
        2'd2: begin
          minstret_next[31:0] = cnt_wdata;
        end
        default: begin
          minstret_next[63:32] = cnt_wdata;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mcycle64   <= 64'd0;
      minstret64 <= 64'd0;
    end else begin
      mcycle64   <= mcycle_next;
      minstret64 <= minstret_next;
    end
  end

endmodule

`default_nettype wire

// File: common/bfs_pkg.sv
`default_nettype none

package bfs_pkg;

  typedef logic [3:0] bfs_idx_t;

  // register indices inside the bfs window, 5..15 unmapped
  localparam bfs_idx_t idx_stat  = 4'd0;
  localparam bfs_idx_t idx_root  = 4'd1;
  localparam bfs_idx_t idx_targ  = 4'd2;
  localparam bfs_idx_t idx_qbase = 4'd3;
  localparam bfs_idx_t idx_qsize = 4'd4;

  typedef struct packed {
    bfs_idx_t    idx;
    logic        wen;
    logic [31:0] wdata;
  } bfs_req_t;

  typedef struct packed {
    logic        error;
    logic [31:0] rdata;
  } bfs_rsp_t;

endpackage

`default_nettype wire

// File: common/csr_pkg.sv
`default_nettype none

package csr_pkg;

  typedef logic [11:0] csr_addr_t;

  // implemented csr addresses
  localparam csr_addr_t addr_mcycle    = 12'hB00;
  localparam csr_addr_t addr_minstret  = 12'hB02;
  localparam csr_addr_t addr_mcycleh   = 12'hB80;
  localparam csr_addr_t addr_minstreth = 12'hB82;
  localparam csr_addr_t addr_muartstat = 12'hFC0;
  localparam csr_addr_t addr_muarttx   = 12'h7C0;
  localparam csr_addr_t addr_ml2stat   = 12'h7E0;

  // upper address byte of the bfs register window
  localparam logic [7:0] addr_bfs_page = 8'h7D;

  typedef enum logic [1:0] {
    op_read  = 2'd0,
    op_write = 2'd1,
    op_set   = 2'd2,
    op_clear = 2'd3
  } csr_op_t;

  // uart status bits
  localparam logic [31:0] uart_stat_rxempty = 32'h0000_0001;
  localparam logic [31:0] uart_stat_txempty = 32'h0000_0004;
  localparam logic [31:0] uart_stat_value   = uart_stat_txempty | uart_stat_rxempty;

  typedef struct packed {
    csr_op_t     op;
    logic [6:0]  robid;
    logic [5:0]  rd;
    logic [31:0] operand;
    csr_addr_t   addr;
  } csr_issue_t;

  typedef struct packed {
    logic        error;
    logic [6:0]  robid;
    logic [5:0]  rd;
    logic [31:0] result;
  } csr_wb_t;

endpackage

`default_nettype wire
